/* common/simil_pkg.sv */
`default_nettype none

package simil_pkg;

    // Reference loading runs first, then every later vector is a candidate
    typedef enum logic [0:0] {
        MODE_LOAD_REF = 1'b0,
        MODE_COMPARE  = 1'b1
    } mode_e;

    parameter int DEF_VECTOR_WIDTH = 32;
    parameter int DEF_REF_DEPTH    = 4;
    parameter int DEF_ID_WIDTH     = 8;
    parameter int DEF_FIFO_DEPTH   = 8;

    // Bits summed by the first popcount stage
    parameter int POP_CHUNK = 4;

    // Enough bits to hold a weight of 0 up to width
    function automatic int cnt_width(input int width);
        return $clog2(width + 1);
    endfunction

    // One chunk stage plus one register per adder level
    function automatic int pop_latency(input int width);
        int chunks;
        chunks = (width + POP_CHUNK - 1) / POP_CHUNK;
        return 1 + $clog2(chunks);
    endfunction

endpackage

`default_nettype wire

/* src/popcount.sv */
`default_nettype none

module popcount #(
    parameter int VECTOR_WIDTH = simil_pkg::DEF_VECTOR_WIDTH
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           i_valid,
    input  logic [VECTOR_WIDTH-1:0]                        i_vector,
    output logic                                           o_valid,
    output logic [VECTOR_WIDTH-1:0]                        o_vector,
    output logic [simil_pkg::cnt_width(VECTOR_WIDTH)-1:0]  o_cnt
);

    localparam int CW     = simil_pkg::cnt_width(VECTOR_WIDTH);
    localparam int LAT    = simil_pkg::pop_latency(VECTOR_WIDTH);
    localparam int LEVELS = LAT - 1;
    localparam int NLEAF  = 2 ** LEVELS;
    localparam int PADW   = NLEAF * simil_pkg::POP_CHUNK;

    // Zero padding fills the leaves that have no real chunk
    logic [PADW-1:0] vec_pad;
    logic [CW-1:0]   sum_q [0:LEVELS][0:NLEAF-1];
    logic [LAT-1:0]  valid_q;
    logic [VECTOR_WIDTH-1:0] vec_q [0:LAT-1];

    assign vec_pad = PADW'(i_vector);

    for (genvar c = 0; c < NLEAF; c++) begin : g_chunk
        always_ff @(posedge clk) begin
            logic [CW-1:0] acc;
            acc = '0;
            for (int b = 0; b < simil_pkg::POP_CHUNK; b++) begin
                acc = acc + CW'(vec_pad[c*simil_pkg::POP_CHUNK+b]);
            end
            sum_q[0][c] <= acc;
        end
    end

    // Each level halves the number of partial sums
    for (genvar l = 1; l <= LEVELS; l++) begin : g_level
        for (genvar i = 0; i < (NLEAF >> l); i++) begin : g_add
            always_ff @(posedge clk) begin
                sum_q[l][i] <= sum_q[l-1][2*i] + sum_q[l-1][2*i+1];
            end
        end
    end

    // Vector and strobe ride along with the adder tree
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= i_valid;
            for (int k = 1; k < LAT; k++) begin
                valid_q[k] <= valid_q[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        vec_q[0] <= i_vector;
        for (int k = 1; k < LAT; k++) begin
            vec_q[k] <= vec_q[k-1];
        end
    end

    assign o_valid  = valid_q[LAT-1];
    assign o_vector = vec_q[LAT-1];
    assign o_cnt    = sum_q[LEVELS][0];

endmodule

`default_nettype wire

/* src/ref_store.sv */
`default_nettype none

module ref_store #(
    parameter int VECTOR_WIDTH = simil_pkg::DEF_VECTOR_WIDTH,
    parameter int REF_DEPTH    = simil_pkg::DEF_REF_DEPTH,
    parameter int ID_WIDTH     = simil_pkg::DEF_ID_WIDTH
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           i_valid,
    input  logic [VECTOR_WIDTH-1:0]                        i_vector,
    input  logic [simil_pkg::cnt_width(VECTOR_WIDTH)-1:0]  i_cnt,
    output logic [VECTOR_WIDTH-1:0]                        o_ref_vector [0:REF_DEPTH-1],
    output logic [simil_pkg::cnt_width(VECTOR_WIDTH)-1:0]  o_ref_cnt    [0:REF_DEPTH-1],
    output logic [ID_WIDTH-1:0]                            o_ref_id     [0:REF_DEPTH-1],
    output logic                                           o_cand_valid,
    output logic [VECTOR_WIDTH-1:0]                        o_cand_vector,
    output logic [simil_pkg::cnt_width(VECTOR_WIDTH)-1:0]  o_cand_cnt,
    output logic [ID_WIDTH-1:0]                            o_cand_id
);

    localparam int RCW = $clog2(REF_DEPTH + 1);

    simil_pkg::mode_e     mode_q;
    logic [RCW-1:0]       ref_count_q;
    logic [ID_WIDTH-1:0]  id_q;
    logic                 load;
    logic                 compare;

    assign load    = i_valid && (mode_q == simil_pkg::MODE_LOAD_REF);
    assign compare = i_valid && (mode_q == simil_pkg::MODE_COMPARE);

    // IDs follow arrival order and simply wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            id_q        <= '0;
            ref_count_q <= '0;
            mode_q      <= simil_pkg::MODE_LOAD_REF;
        end else begin
            if (i_valid) begin
                id_q <= id_q + 1'b1;
            end
            if (load) begin
                ref_count_q <= ref_count_q + 1'b1;
                if (ref_count_q == RCW'(REF_DEPTH - 1)) begin
                    mode_q <= simil_pkg::MODE_COMPARE;
                end
            end
        end
    end

    // Newest reference enters slot 0
    always_ff @(posedge clk) begin
        if (load) begin
            o_ref_vector[0] <= i_vector;
            o_ref_cnt[0]    <= i_cnt;
            o_ref_id[0]     <= id_q;
            for (int s = 1; s < REF_DEPTH; s++) begin
                o_ref_vector[s] <= o_ref_vector[s-1];
                o_ref_cnt[s]    <= o_ref_cnt[s-1];
                o_ref_id[s]     <= o_ref_id[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_cand_valid <= 1'b0;
        end else begin
            o_cand_valid <= compare;
        end
    end

    always_ff @(posedge clk) begin
        if (compare) begin
            o_cand_vector <= i_vector;
            o_cand_cnt    <= i_cnt;
            o_cand_id     <= id_q;
        end
    end

endmodule

`default_nettype wire

/* src/pair_lane.sv */
`default_nettype none

module pair_lane #(
    parameter int VECTOR_WIDTH = simil_pkg::DEF_VECTOR_WIDTH,
    parameter int ID_WIDTH     = simil_pkg::DEF_ID_WIDTH
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           i_threshold_wr,
    input  logic [simil_pkg::cnt_width(VECTOR_WIDTH):0]    i_threshold,
    input  logic [VECTOR_WIDTH-1:0]                        i_ref_vector,
    input  logic [simil_pkg::cnt_width(VECTOR_WIDTH)-1:0]  i_ref_cnt,
    input  logic [ID_WIDTH-1:0]                            i_ref_id,
    input  logic                                           i_cand_valid,
    input  logic [VECTOR_WIDTH-1:0]                        i_cand_vector,
    input  logic [simil_pkg::cnt_width(VECTOR_WIDTH)-1:0]  i_cand_cnt,
    input  logic [ID_WIDTH-1:0]                            i_cand_id,
    output logic                                           o_pair_wr,
    output logic [ID_WIDTH-1:0]                            o_pair_ref_id,
    output logic [ID_WIDTH-1:0]                            o_pair_cand_id
);

    localparam int CW  = simil_pkg::cnt_width(VECTOR_WIDTH);
    localparam int MW  = CW + 1;
    localparam int LAT = simil_pkg::pop_latency(VECTOR_WIDTH);
    localparam int DW  = 2 * CW + 2 * ID_WIDTH;

    logic [CW-1:0]  and_cnt;
    logic           and_valid;
    logic [MW-1:0]  threshold_q;
    logic [MW-1:0]  metric;
    logic [DW-1:0]  dly_q [0:LAT-1];
    logic [CW-1:0]  ref_cnt_d;
    logic [CW-1:0]  cand_cnt_d;
    logic [ID_WIDTH-1:0] ref_id_d;
    logic [ID_WIDTH-1:0] cand_id_d;

    popcount #(
        .VECTOR_WIDTH (VECTOR_WIDTH)
    ) u_and_pop (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (i_cand_valid),
        .i_vector (i_ref_vector & i_cand_vector),
        .o_valid  (and_valid),
        .o_vector (),
        .o_cnt    (and_cnt)
    );

    // Weights and IDs wait for the AND count
    always_ff @(posedge clk) begin
        dly_q[0] <= {i_ref_cnt, i_cand_cnt, i_ref_id, i_cand_id};
        for (int k = 1; k < LAT; k++) begin
            dly_q[k] <= dly_q[k-1];
        end
    end

    assign {ref_cnt_d, cand_cnt_d, ref_id_d, cand_id_d} = dly_q[LAT-1];

    // Equals the popcount of the OR, so it never goes negative
    assign metric = MW'(ref_cnt_d) + MW'(cand_cnt_d) - MW'(and_cnt);

    always_ff @(posedge clk) begin
        if (rst) begin
            threshold_q <= '0;
            o_pair_wr   <= 1'b0;
        end else begin
            if (i_threshold_wr) begin
                threshold_q <= i_threshold;
            end
            o_pair_wr <= and_valid && (metric < threshold_q);
        end
    end

    always_ff @(posedge clk) begin
        o_pair_ref_id  <= ref_id_d;
        o_pair_cand_id <= cand_id_d;
    end

endmodule

`default_nettype wire

/* fifo_tree/id_fifo.sv */
`default_nettype none

module id_fifo #(
    parameter int WIDTH = 2 * simil_pkg::DEF_ID_WIDTH,
    parameter int DEPTH = simil_pkg::DEF_FIFO_DEPTH
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_wr,
    input  logic [WIDTH-1:0]             i_data,
    input  logic                         i_rd,
    output logic [WIDTH-1:0]             o_data,
    output logic                         o_empty,
    output logic                         o_full,
    output logic [$clog2(DEPTH+1)-1:0]   o_count
);

    localparam int PW  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [0:DEPTH-1];
    logic [PW-1:0]    wr_ptr;
    logic [PW-1:0]    rd_ptr;
    logic             wr_ok;
    logic             rd_ok;

    assign o_empty = (o_count == '0);
    assign o_full  = (o_count == CNW'(DEPTH));
    assign wr_ok   = i_wr && !o_full;
    assign rd_ok   = i_rd && !o_empty;

    // Head is visible without a read
    assign o_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_ok && !rd_ok) begin
                o_count <= o_count + 1'b1;
            end else if (rd_ok && !wr_ok) begin
                o_count <= o_count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* fifo_tree/fifo_tree.sv */
`default_nettype none

module fifo_tree #(
    parameter int REF_DEPTH  = simil_pkg::DEF_REF_DEPTH,
    parameter int ID_WIDTH   = simil_pkg::DEF_ID_WIDTH,
    parameter int FIFO_DEPTH = simil_pkg::DEF_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [REF_DEPTH-1:0] i_leaf_wr,
    input  logic [ID_WIDTH-1:0]  i_leaf_ref_id  [0:REF_DEPTH-1],
    input  logic [ID_WIDTH-1:0]  i_leaf_cand_id [0:REF_DEPTH-1],
    input  logic                 i_root_rd,
    output logic                 o_root_valid,
    output logic [ID_WIDTH-1:0]  o_root_ref_id,
    output logic [ID_WIDTH-1:0]  o_root_cand_id
);

    localparam int NODES = 2 * REF_DEPTH - 1;
    localparam int DW    = 2 * ID_WIDTH;
    localparam int CNW   = $clog2(FIFO_DEPTH + 1);

    // Node n has children 2n and 2n+1 and the leaves start at REF_DEPTH
    logic [NODES:1]   wr;
    logic [NODES:1]   rd;
    logic [NODES:1]   empty;
    logic [NODES:1]   full;
    logic [DW-1:0]    din   [1:NODES];
    logic [DW-1:0]    dout  [1:NODES];
    logic [CNW-1:0]   count [1:NODES];

    for (genvar n = 1; n <= NODES; n++) begin : g_node
        id_fifo #(
            .WIDTH (DW),
            .DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk     (clk),
            .rst     (rst),
            .i_wr    (wr[n]),
            .i_data  (din[n]),
            .i_rd    (rd[n]),
            .o_data  (dout[n]),
            .o_empty (empty[n]),
            .o_full  (full[n]),
            .o_count (count[n])
        );

        if (n >= REF_DEPTH) begin : g_leaf
            assign wr[n]  = i_leaf_wr[n-REF_DEPTH];
            assign din[n] = {i_leaf_ref_id[n-REF_DEPTH], i_leaf_cand_id[n-REF_DEPTH]};
        end else begin : g_merge
            logic sel_left;

            // Left only wins when strictly fuller
            assign sel_left   = count[2*n] > count[2*n+1];
            assign wr[n]      = !full[n] && (sel_left ? !empty[2*n] : !empty[2*n+1]);
            assign din[n]     = sel_left ? dout[2*n] : dout[2*n+1];
            assign rd[2*n]    = sel_left && wr[n];
            assign rd[2*n+1]  = !sel_left && wr[n];
        end
    end

    assign rd[1]          = i_root_rd;
    assign o_root_valid   = !empty[1];
    assign o_root_ref_id  = dout[1][DW-1:ID_WIDTH];
    assign o_root_cand_id = dout[1][ID_WIDTH-1:0];

endmodule

`default_nettype wire

/* src/simil_top.sv */
`default_nettype none

module simil_top #(
    parameter int VECTOR_WIDTH = simil_pkg::DEF_VECTOR_WIDTH,
    parameter int REF_DEPTH    = simil_pkg::DEF_REF_DEPTH,
    parameter int ID_WIDTH     = simil_pkg::DEF_ID_WIDTH,
    parameter int FIFO_DEPTH   = simil_pkg::DEF_FIFO_DEPTH
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  logic                                           i_valid,
    input  logic [VECTOR_WIDTH-1:0]                        i_vector,
    input  logic                                           i_threshold_wr,
    input  logic [simil_pkg::cnt_width(VECTOR_WIDTH):0]    i_threshold,
    input  logic                                           i_pair_read,
    output logic                                           o_pair_valid,
    output logic [ID_WIDTH-1:0]                            o_pair_ref_id,
    output logic [ID_WIDTH-1:0]                            o_pair_cand_id
);

    localparam int CW = simil_pkg::cnt_width(VECTOR_WIDTH);

    logic                     pop_valid;
    logic [VECTOR_WIDTH-1:0]  pop_vector;
    logic [CW-1:0]            pop_cnt;

    logic [VECTOR_WIDTH-1:0]  ref_vector [0:REF_DEPTH-1];
    logic [CW-1:0]            ref_cnt    [0:REF_DEPTH-1];
    logic [ID_WIDTH-1:0]      ref_id     [0:REF_DEPTH-1];

    logic                     cand_valid;
    logic [VECTOR_WIDTH-1:0]  cand_vector;
    logic [CW-1:0]            cand_cnt;
    logic [ID_WIDTH-1:0]      cand_id;

    logic [REF_DEPTH-1:0]     leaf_wr;
    logic [ID_WIDTH-1:0]      leaf_ref_id  [0:REF_DEPTH-1];
    logic [ID_WIDTH-1:0]      leaf_cand_id [0:REF_DEPTH-1];

    // Input weight
    popcount #(
        .VECTOR_WIDTH (VECTOR_WIDTH)
    ) u_in_pop (
        .clk      (clk),
        .rst      (rst),
        .i_valid  (i_valid),
        .i_vector (i_vector),
        .o_valid  (pop_valid),
        .o_vector (pop_vector),
        .o_cnt    (pop_cnt)
    );

    ref_store #(
        .VECTOR_WIDTH (VECTOR_WIDTH),
        .REF_DEPTH    (REF_DEPTH),
        .ID_WIDTH     (ID_WIDTH)
    ) u_ref_store (
        .clk           (clk),
        .rst           (rst),
        .i_valid       (pop_valid),
        .i_vector      (pop_vector),
        .i_cnt         (pop_cnt),
        .o_ref_vector  (ref_vector),
        .o_ref_cnt     (ref_cnt),
        .o_ref_id      (ref_id),
        .o_cand_valid  (cand_valid),
        .o_cand_vector (cand_vector),
        .o_cand_cnt    (cand_cnt),
        .o_cand_id     (cand_id)
    );

    // Candidate goes to every lane in the same cycle
    for (genvar g = 0; g < REF_DEPTH; g++) begin : g_lane
        pair_lane #(
            .VECTOR_WIDTH (VECTOR_WIDTH),
            .ID_WIDTH     (ID_WIDTH)
        ) u_lane (
            .clk            (clk),
            .rst            (rst),
            .i_threshold_wr (i_threshold_wr),
            .i_threshold    (i_threshold),
            .i_ref_vector   (ref_vector[g]),
            .i_ref_cnt      (ref_cnt[g]),
            .i_ref_id       (ref_id[g]),
            .i_cand_valid   (cand_valid),
            .i_cand_vector  (cand_vector),
            .i_cand_cnt     (cand_cnt),
            .i_cand_id      (cand_id),
            .o_pair_wr      (leaf_wr[g]),
            .o_pair_ref_id  (leaf_ref_id[g]),
            .o_pair_cand_id (leaf_cand_id[g])
        );
    end

    fifo_tree #(
        .REF_DEPTH  (REF_DEPTH),
        .ID_WIDTH   (ID_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo_tree (
        .clk            (clk),
        .rst            (rst),
        .i_leaf_wr      (leaf_wr),
        .i_leaf_ref_id  (leaf_ref_id),
        .i_leaf_cand_id (leaf_cand_id),
        .i_root_rd      (i_pair_read),
        .o_root_valid   (o_pair_valid),
        .o_root_ref_id  (o_pair_ref_id),
        .o_root_cand_id (o_pair_cand_id)
    );

endmodule

`default_nettype wire

/* tests/simil_checker.sv */
`default_nettype none

module simil_checker #(
    parameter int ID_WIDTH = simil_pkg::DEF_ID_WIDTH,
    parameter int MAX_EXP  = 64
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_pair_valid,
    input  logic                  i_pair_read,
    input  logic [ID_WIDTH-1:0]   i_pair_ref_id,
    input  logic [ID_WIDTH-1:0]   i_pair_cand_id,
    input  logic                  i_quiet,
    input  logic [2*ID_WIDTH-1:0] i_exp_pairs [0:MAX_EXP-1],
    input  int                    i_exp_count,
    input  logic                  i_final,
    output int                    o_seen,
    output int                    o_mismatch,
    output int                    o_missing,
    output int                    o_other
);

    timeunit 1ns;
    timeprecision 1ps;

    logic seen [0:MAX_EXP-1];
    logic quiet_reported;
    logic final_done;

    initial begin
        for (int i = 0; i < MAX_EXP; i++) begin
            seen[i] = 1'b0;
        end
        quiet_reported = 1'b0;
        final_done     = 1'b0;
        o_seen         = 0;
        o_mismatch     = 0;
        o_missing      = 0;
        o_other        = 0;
    end

    // Index of the pair in the expected set, or -1
    function automatic int find_pair(input logic [2*ID_WIDTH-1:0] pair);
        int idx;
        idx = -1;
        for (int i = 0; i < i_exp_count; i++) begin
            if (i_exp_pairs[i] == pair && idx < 0) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    // A pair leaves the DUT only when valid and read meet in one cycle
    always @(posedge clk) begin
        int idx;
        if (!rst) begin
            if (i_quiet && i_pair_valid && !quiet_reported) begin
                $display("Pair output went valid at %0d ns while the threshold was still zero",
                         $time);
                o_other++;
                quiet_reported = 1'b1;
            end
            if (i_pair_valid && i_pair_read) begin
                idx = find_pair({i_pair_ref_id, i_pair_cand_id});
                if (idx < 0) begin
                    $display("MISMATCH time %0d ns: pair ref %0d cand %0d is not expected",
                             $time, i_pair_ref_id, i_pair_cand_id);
                    o_mismatch++;
                end else if (seen[idx]) begin
                    $display("MISMATCH time %0d ns: pair ref %0d cand %0d came out twice",
                             $time, i_pair_ref_id, i_pair_cand_id);
                    o_mismatch++;
                end else begin
                    seen[idx] = 1'b1;
                    o_seen++;
                end
            end
        end
        // Sweep for pairs that never arrived
        if (i_final && !final_done) begin
            for (int i = 0; i < i_exp_count; i++) begin
                if (!seen[i]) begin
                    $display("Expected pair ref %0d cand %0d never came out",
                             i_exp_pairs[i][2*ID_WIDTH-1:ID_WIDTH],
                             i_exp_pairs[i][ID_WIDTH-1:0]);
                    o_missing++;
                end
            end
            final_done = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tests/simil_tb.sv */
`default_nettype none

module simil_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int VW      = simil_pkg::DEF_VECTOR_WIDTH;
    localparam int RD      = simil_pkg::DEF_REF_DEPTH;
    localparam int IW      = simil_pkg::DEF_ID_WIDTH;
    localparam int FD      = simil_pkg::DEF_FIFO_DEPTH;
    localparam int TW      = simil_pkg::cnt_width(VW) + 1;
    localparam int MAX_EXP = 64;
    localparam int DRAIN   = 30;

    logic           clk;
    logic           rst;
    logic           valid;
    logic [VW-1:0]  vector;
    logic           threshold_wr;
    logic [TW-1:0]  threshold;
    logic           pair_read;
    logic           pair_valid;
    logic [IW-1:0]  pair_ref_id;
    logic [IW-1:0]  pair_cand_id;

    byte             cmd_q [$];
    logic [31:0]     arg_q [$];
    logic [2*IW-1:0] exp_pairs [0:MAX_EXP-1];
    int              exp_count;
    int              parse_errors;
    logic            stim_open;
    int              cycle_count;
    int              cycle_limit;
    logic            quiet;
    logic            final_check;
    int              seen_count;
    int              mismatch_errors;
    int              missing_errors;
    int              other_errors;

    simil_top #(
        .VECTOR_WIDTH (VW),
        .REF_DEPTH    (RD),
        .ID_WIDTH     (IW),
        .FIFO_DEPTH   (FD)
    ) i_dut (
        .clk            (clk),
        .rst            (rst),
        .i_valid        (valid),
        .i_vector       (vector),
        .i_threshold_wr (threshold_wr),
        .i_threshold    (threshold),
        .i_pair_read    (pair_read),
        .o_pair_valid   (pair_valid),
        .o_pair_ref_id  (pair_ref_id),
        .o_pair_cand_id (pair_cand_id)
    );

    simil_checker #(
        .ID_WIDTH (IW),
        .MAX_EXP  (MAX_EXP)
    ) u_check (
        .clk            (clk),
        .rst            (rst),
        .i_pair_valid   (pair_valid),
        .i_pair_read    (pair_read),
        .i_pair_ref_id  (pair_ref_id),
        .i_pair_cand_id (pair_cand_id),
        .i_quiet        (quiet),
        .i_exp_pairs    (exp_pairs),
        .i_exp_count    (exp_count),
        .i_final        (final_check),
        .o_seen         (seen_count),
        .o_mismatch     (mismatch_errors),
        .o_missing      (missing_errors),
        .o_other        (other_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Random read strobes on about half of the cycles
    initial begin : read_strobes
        logic [31:0] rnd;
        pair_read = 1'b0;
        rnd = $urandom(89);
        forever begin
            @(posedge clk);
            #1;
            rnd = $urandom;
            pair_read = rnd[0];
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d expected pairs seen",
                     cycle_count, seen_count, exp_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // Commands are queued first so the timeout limit is known up front
    task automatic read_stim();
        int    fd;
        string line;
        string tok;
        byte   code;
        int    a;
        int    b;
        int    steps;
        steps = 0;
        fd = $fopen("tests/simil_stim.txt", "r");
        stim_open = (fd != 0);
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 1) begin
                continue;
            end
            code = line.getc(0);
            tok  = line.substr(2, line.len() - 1);
            case (code)
                "W", "G": begin
                    if ($sscanf(tok, "%d", a) != 1) begin
                        $display("Bad number in stimulus line: %s", line);
                        parse_errors++;
                    end else begin
                        cmd_q.push_back(code);
                        arg_q.push_back(a);
                        if (code == "G") begin
                            steps += a;
                        end
                    end
                end
                "V": begin
                    if ($sscanf(tok, "%h", a) != 1) begin
                        $display("Bad vector in stimulus line: %s", line);
                        parse_errors++;
                    end else begin
                        cmd_q.push_back(code);
                        arg_q.push_back(a);
                        steps += 1;
                    end
                end
                "P": begin
                    if ($sscanf(tok, "%d %d", a, b) != 2 || exp_count >= MAX_EXP) begin
                        $display("Expected pair line cannot be used: %s", line);
                        parse_errors++;
                    end else begin
                        exp_pairs[exp_count] = {a[IW-1:0], b[IW-1:0]};
                        exp_count++;
                    end
                end
                "R": begin
                    cmd_q.push_back(code);
                    arg_q.push_back(32'd0);
                end
                "#", "\n", " ": begin
                end
                default: begin
                    $display("Unknown command in stimulus line: %s", line);
                    parse_errors++;
                end
            endcase
        end
        $fclose(fd);
        cycle_limit = 2 * steps + 200;
    endtask

    task automatic clear_strobes();
        valid        = 1'b0;
        threshold_wr = 1'b0;
    endtask

    task automatic apply_reset();
        simil_pkg::mode_e start_mode;
        start_mode = simil_pkg::MODE_LOAD_REF;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        $display("Reset released at %0d ns, DUT starts in %s", $time, start_mode.name());
    endtask

    task automatic run_stim();
        for (int i = 0; i < cmd_q.size(); i++) begin
            if (cmd_q[i] == "G") begin
                repeat (arg_q[i]) begin
                    @(posedge clk);
                    #1;
                    clear_strobes();
                end
            end else begin
                @(posedge clk);
                #1;
                clear_strobes();
                case (cmd_q[i])
                    "W": begin
                        threshold_wr = 1'b1;
                        threshold    = arg_q[i][TW-1:0];
                        quiet        = 1'b0;
                    end
                    "V": begin
                        valid  = 1'b1;
                        vector = arg_q[i];
                    end
                    default: begin
                        apply_reset();
                    end
                endcase
            end
        end
        @(posedge clk);
        #1;
        clear_strobes();
    endtask

    initial begin : main
        rst          = 1'b1;
        valid        = 1'b0;
        vector       = '0;
        threshold_wr = 1'b0;
        threshold    = '0;
        quiet        = 1'b1;
        final_check  = 1'b0;
        exp_count    = 0;
        parse_errors = 0;
        cycle_limit  = 0;
        for (int i = 0; i < MAX_EXP; i++) begin
            exp_pairs[i] = '0;
        end
        read_stim();
        if (!stim_open) begin
            $display("Cannot open tests/simil_stim.txt for reading");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            apply_reset();
            run_stim();
            while (seen_count < exp_count) begin
                @(posedge clk);
                #1;
            end
            // Extra window to catch pairs that should not exist
            repeat (DRAIN) @(posedge clk);
            #1;
            final_check = 1'b1;
            @(posedge clk);
            #1;
            $display("Error counts: mismatch %0d, missing %0d, other %0d",
                     mismatch_errors, missing_errors, other_errors + parse_errors);
            if (mismatch_errors + missing_errors + other_errors + parse_errors == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tests/simil_stim.txt */
# W <threshold, dec> | V <vector, hex> | G <idle cycles, dec> | R (reset)
# P <ref id, dec> <cand id, dec> is an expected output pair, in any order
# Threshold still zero: four references and two candidates, no pairs
V 0000000F
V 000000F0
V 00000F00
V 0000F000
V 0000000F
V 00000000
G 30
R
# References 0 to 3 load under a high threshold
W 10
V 000000FF
V 0000FF00
V 00FF0000
V FF000000
# Candidates 4 to 7, metric is the popcount of ref OR cand
V 0000000F
V 00000300
V 00018000
V 80000001
G 20
P 0 4
P 1 5
P 1 6
P 2 6
P 0 7
P 3 7
# Tighter threshold, only subsets of a reference match
W 9
V 0000000F
V 00018000
V 80000001
V 0F000000
G 20
P 0 8
P 3 11
# Burst of candidates that hit every reference
W 12
V 00000000
V 00010001
V 00000003
V 81000000
V 0000000F
G 40
P 0 12
P 1 12
P 2 12
P 3 12
P 0 13
P 1 13
P 2 13
P 3 13
P 0 14
P 1 14
P 2 14
P 3 14
P 0 15
P 1 15
P 2 15
P 3 15
P 0 16

/* vec_simil.f */
common/simil_pkg.sv
src/popcount.sv
src/ref_store.sv
src/pair_lane.sv
fifo_tree/id_fifo.sv
fifo_tree/fifo_tree.sv
src/simil_top.sv
tests/simil_checker.sv
tests/simil_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the log holds the pass line

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -f vec_simil.f --top-module simil_tb -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"$BUILD_DIR/Vsimil_tb" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
